// ==== dw_pkg.sv ====
package dw_pkg;

  // Default port widths
  localparam int unsigned SlvDataWidth = 64;
  localparam int unsigned MstDataWidth = 32;
  localparam int unsigned AddrWidth    = 16;
  localparam int unsigned IdWidth      = 2;

  // Concurrent reads in flight
  localparam int unsigned NumLanes = 4;

  // AXI burst length, beats minus one
  typedef logic [7:0] len_t;

  // AXI size, log2 of bytes per beat
  typedef logic [2:0] size_t;

  // AXI read response
  typedef logic [1:0] resp_t;

  // Response codes, ordered by severity
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespExokay = 2'b01;
  localparam resp_t RespSlverr = 2'b10;
  localparam resp_t RespDecerr = 2'b11;

endpackage

// ==== dw_ar_dispatch.sv ====
module dw_ar_dispatch #(
  parameter int unsigned NumLanes = 4,
  parameter int unsigned IdWidth  = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              slv_ar_valid_i,
  input  logic [IdWidth-1:0]                slv_ar_id_i,
  input  logic [NumLanes-1:0]               lane_idle_i,
  input  logic [NumLanes-1:0][IdWidth-1:0]  lane_id_i,
  output logic                              slv_ar_ready_o,
  output logic [NumLanes-1:0]               lane_start_o
);

  logic                ready_en_q;
  logic                id_clash;
  logic [NumLanes-1:0] idle_sel;

  // Keeps the AR port closed in the first cycle after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
    end
  end

  // Busy lane with the same ID, and the lowest idle lane
  always_comb begin
    id_clash = 1'b0;
    idle_sel = '0;
    for (int i = NumLanes - 1; i >= 0; i--) begin
      if (!lane_idle_i[i] && (lane_id_i[i] == slv_ar_id_i)) begin
        id_clash = 1'b1;
      end
      if (lane_idle_i[i]) begin
        idle_sel = NumLanes'(1) << i;
      end
    end
  end

  // A busy lane owning this ID blocks the request until it drains,
  // so an ID never lives on two lanes at once
  assign slv_ar_ready_o = ready_en_q && !id_clash && (|lane_idle_i);

  assign lane_start_o = (slv_ar_valid_i && slv_ar_ready_o) ? idle_sel : '0;

endmodule

// ==== dw_read_lane.sv ====
module dw_read_lane #(
  parameter int unsigned SlvDataWidth = 64,
  parameter int unsigned MstDataWidth = 32,
  parameter int unsigned AddrWidth    = 16,
  parameter int unsigned IdWidth      = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    start_i,
  input  logic [IdWidth-1:0]      slv_ar_id_i,
  input  logic [AddrWidth-1:0]    slv_ar_addr_i,
  input  dw_pkg::len_t            slv_ar_len_i,
  input  dw_pkg::size_t           slv_ar_size_i,
  input  logic                    ar_gnt_i,
  input  logic                    mst_r_valid_i,
  input  logic [IdWidth-1:0]      mst_r_id_i,
  input  logic [MstDataWidth-1:0] mst_r_data_i,
  input  dw_pkg::resp_t           mst_r_resp_i,
  input  logic                    mst_r_last_i,
  input  logic                    r_gnt_i,
  output logic                    idle_o,
  output logic [IdWidth-1:0]      id_o,
  output logic                    ar_valid_o,
  output logic [AddrWidth-1:0]    ar_addr_o,
  output dw_pkg::len_t            ar_len_o,
  output dw_pkg::size_t           ar_size_o,
  output logic                    mst_r_ready_o,
  output logic                    r_valid_o,
  output logic [SlvDataWidth-1:0] r_data_o,
  output dw_pkg::resp_t           r_resp_o,
  output logic                    r_last_o
);

  localparam int unsigned SlvStrb    = SlvDataWidth / 8;
  localparam int unsigned MstStrb    = MstDataWidth / 8;
  localparam int unsigned SlvMaxSize = $clog2(SlvStrb);
  localparam int unsigned MstMaxSize = $clog2(MstStrb);
  localparam int unsigned GrpW       = (SlvMaxSize > MstMaxSize) ? SlvMaxSize - MstMaxSize : 1;

  localparam logic [1:0] StIdle = 2'd0;
  localparam logic [1:0] StAddr = 2'd1;
  localparam logic [1:0] StData = 2'd2;

  logic [1:0]              state_q;
  logic                    r_valid_q;
  logic [GrpW-1:0]         grp_cnt_q;
  logic [GrpW-1:0]         grp_last_q;
  logic [IdWidth-1:0]      id_q;
  logic [AddrWidth-1:0]    addr_q;
  dw_pkg::len_t            len_q;
  dw_pkg::len_t            mst_len_q;
  dw_pkg::size_t           mst_size_q;
  logic [SlvDataWidth-1:0] data_q;
  dw_pkg::resp_t           resp_q;

  dw_pkg::size_t           shift;
  logic [15:0]             ext_len;
  dw_pkg::len_t            new_len;
  dw_pkg::size_t           new_size;
  logic [GrpW-1:0]         new_grp_last;
  int unsigned             beat_bytes;
  int unsigned             mst_off;
  int unsigned             word_sel;
  logic [SlvDataWidth-1:0] gather;
  logic                    start_acc;
  logic                    beat_acc;
  logic                    grp_done;

  // Master AR rewrite of the incoming request
  always_comb begin
    shift = '0;
    if (slv_ar_size_i > dw_pkg::size_t'(MstMaxSize)) begin
      shift = slv_ar_size_i - dw_pkg::size_t'(MstMaxSize);
    end
    ext_len      = (16'(slv_ar_len_i) + 16'd1) << shift;
    new_len      = dw_pkg::len_t'(ext_len - 16'd1);
    new_size     = (shift != '0) ? dw_pkg::size_t'(MstMaxSize) : slv_ar_size_i;
    new_grp_last = GrpW'((1 << shift) - 1);
  end

  // Byte steering of one master beat into the slave word
  always_comb begin
    beat_bytes = 1 << mst_size_q;
    mst_off    = int'(addr_q) & (MstStrb - 1);
    word_sel   = (int'(addr_q) & (SlvStrb - 1)) >> MstMaxSize;
    gather     = data_q;
    for (int b = 0; b < MstStrb; b++) begin
      if ((b >= mst_off) && (b < mst_off + beat_bytes)) begin
        gather[8 * (word_sel * MstStrb + b) +: 8] = mst_r_data_i[8 * b +: 8];
      end
    end
  end

  assign start_acc = start_i && (state_q == StIdle);

  // Only beats of our own ID, and only while no slave beat is pending
  assign mst_r_ready_o = (state_q == StData) && !r_valid_q && (mst_r_id_i == id_q);
  assign beat_acc      = mst_r_valid_i && mst_r_ready_o;
  // Last beat of the burst always closes the group
  assign grp_done      = (grp_cnt_q == grp_last_q) || mst_r_last_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= StIdle;
      r_valid_q <= 1'b0;
      grp_cnt_q <= '0;
    end else begin
      case (state_q)
        StIdle: if (start_i) state_q <= StAddr;
        StAddr: if (ar_gnt_i) state_q <= StData;
        StData: if (r_gnt_i && (len_q == '0)) state_q <= StIdle;
        default: state_q <= StIdle;
      endcase
      if (beat_acc) begin
        if (grp_done) begin
          grp_cnt_q <= '0;
          r_valid_q <= 1'b1;
        end else begin
          grp_cnt_q <= grp_cnt_q + 1'b1;
        end
      end
      if (r_gnt_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_acc) begin
      id_q       <= slv_ar_id_i;
      addr_q     <= slv_ar_addr_i;
      len_q      <= slv_ar_len_i;
      mst_len_q  <= new_len;
      mst_size_q <= new_size;
      grp_last_q <= new_grp_last;
      data_q     <= '0;
    end
    if (beat_acc) begin
      data_q <= gather;
      addr_q <= addr_q + AddrWidth'(beat_bytes);
      // Worst response of the group wins
      if ((grp_cnt_q == '0) || (mst_r_resp_i > resp_q)) begin
        resp_q <= mst_r_resp_i;
      end
    end
    if (r_gnt_i) begin
      data_q <= '0;
      len_q  <= len_q - 1'b1;
    end
  end

  assign idle_o     = (state_q == StIdle);
  assign id_o       = id_q;
  assign ar_valid_o = (state_q == StAddr);
  assign ar_addr_o  = addr_q;
  assign ar_len_o   = mst_len_q;
  assign ar_size_o  = mst_size_q;
  assign r_valid_o  = r_valid_q;
  assign r_data_o   = data_q;
  assign r_resp_o   = resp_q;
  assign r_last_o   = (len_q == '0);

endmodule

// ==== dw_lane_arbiter.sv ====
module dw_lane_arbiter #(
  parameter int unsigned NumLanes     = 4,
  parameter int unsigned SlvDataWidth = 64,
  parameter int unsigned AddrWidth    = 16,
  parameter int unsigned IdWidth      = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic [NumLanes-1:0]                  lane_ar_valid_i,
  input  logic [NumLanes-1:0][IdWidth-1:0]     lane_ar_id_i,
  input  logic [NumLanes-1:0][AddrWidth-1:0]   lane_ar_addr_i,
  input  dw_pkg::len_t [NumLanes-1:0]          lane_ar_len_i,
  input  dw_pkg::size_t [NumLanes-1:0]         lane_ar_size_i,
  input  logic                                 mst_ar_ready_i,
  input  logic [NumLanes-1:0]                  lane_r_valid_i,
  input  logic [NumLanes-1:0][SlvDataWidth-1:0] lane_r_data_i,
  input  dw_pkg::resp_t [NumLanes-1:0]         lane_r_resp_i,
  input  logic [NumLanes-1:0]                  lane_r_last_i,
  input  logic [NumLanes-1:0][IdWidth-1:0]     lane_id_i,
  input  logic [NumLanes-1:0]                  lane_mst_r_ready_i,
  input  logic                                 slv_r_ready_i,
  output logic [NumLanes-1:0]                  ar_gnt_o,
  output logic                                 mst_ar_valid_o,
  output logic [IdWidth-1:0]                   mst_ar_id_o,
  output logic [AddrWidth-1:0]                 mst_ar_addr_o,
  output dw_pkg::len_t                         mst_ar_len_o,
  output dw_pkg::size_t                        mst_ar_size_o,
  output logic [NumLanes-1:0]                  r_gnt_o,
  output logic                                 slv_r_valid_o,
  output logic [IdWidth-1:0]                   slv_r_id_o,
  output logic [SlvDataWidth-1:0]              slv_r_data_o,
  output dw_pkg::resp_t                        slv_r_resp_o,
  output logic                                 slv_r_last_o,
  output logic                                 mst_r_ready_o
);

  localparam int unsigned IdxW = (NumLanes > 1) ? $clog2(NumLanes) : 1;

  logic [IdxW-1:0] ar_ptr_q;
  logic [IdxW-1:0] r_ptr_q;
  logic [IdxW-1:0] ar_sel;
  logic [IdxW-1:0] r_sel;

  // First requester at or after the pointer
  function automatic logic [IdxW-1:0] rr_pick(input logic [NumLanes-1:0] req,
                                               input logic [IdxW-1:0] ptr);
    logic [IdxW-1:0] idx;
    rr_pick = ptr;
    for (int k = NumLanes - 1; k >= 0; k--) begin
      idx = IdxW'((int'(ptr) + k) % NumLanes);
      if (req[idx]) begin
        rr_pick = idx;
      end
    end
  endfunction

  assign ar_sel = rr_pick(lane_ar_valid_i, ar_ptr_q);
  assign r_sel  = rr_pick(lane_r_valid_i, r_ptr_q);

  assign mst_ar_valid_o = lane_ar_valid_i[ar_sel];
  assign mst_ar_id_o    = lane_ar_id_i[ar_sel];
  assign mst_ar_addr_o  = lane_ar_addr_i[ar_sel];
  assign mst_ar_len_o   = lane_ar_len_i[ar_sel];
  assign mst_ar_size_o  = lane_ar_size_i[ar_sel];
  assign ar_gnt_o = (mst_ar_valid_o && mst_ar_ready_i) ? NumLanes'(1) << ar_sel : '0;

  assign slv_r_valid_o = lane_r_valid_i[r_sel];
  assign slv_r_id_o    = lane_id_i[r_sel];
  assign slv_r_data_o  = lane_r_data_i[r_sel];
  assign slv_r_resp_o  = lane_r_resp_i[r_sel];
  assign slv_r_last_o  = lane_r_last_i[r_sel];
  assign r_gnt_o = (slv_r_valid_o && slv_r_ready_i) ? NumLanes'(1) << r_sel : '0;

  assign mst_r_ready_o = |lane_mst_r_ready_i;

  // A stalled grant parks the pointer on its lane, which locks it in
  // since lane valids hold; a completed grant moves past the winner
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ar_ptr_q <= '0;
      r_ptr_q  <= '0;
    end else begin
      if (mst_ar_valid_o) begin
        ar_ptr_q <= mst_ar_ready_i ? IdxW'((int'(ar_sel) + 1) % NumLanes) : ar_sel;
      end
      if (slv_r_valid_o) begin
        r_ptr_q <= slv_r_ready_i ? IdxW'((int'(r_sel) + 1) % NumLanes) : r_sel;
      end
    end
  end

endmodule

// ==== axi_read_downsizer.sv ====
module axi_read_downsizer #(
  parameter int unsigned SlvDataWidth = dw_pkg::SlvDataWidth,
  parameter int unsigned MstDataWidth = dw_pkg::MstDataWidth,
  parameter int unsigned AddrWidth    = dw_pkg::AddrWidth,
  parameter int unsigned IdWidth      = dw_pkg::IdWidth,
  parameter int unsigned NumLanes     = dw_pkg::NumLanes
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Slave port
  input  logic                    slv_ar_valid_i,
  input  logic [IdWidth-1:0]      slv_ar_id_i,
  input  logic [AddrWidth-1:0]    slv_ar_addr_i,
  input  dw_pkg::len_t            slv_ar_len_i,
  input  dw_pkg::size_t           slv_ar_size_i,
  output logic                    slv_ar_ready_o,
  output logic                    slv_r_valid_o,
  output logic [IdWidth-1:0]      slv_r_id_o,
  output logic [SlvDataWidth-1:0] slv_r_data_o,
  output dw_pkg::resp_t           slv_r_resp_o,
  output logic                    slv_r_last_o,
  input  logic                    slv_r_ready_i,
  // Master port
  output logic                    mst_ar_valid_o,
  output logic [IdWidth-1:0]      mst_ar_id_o,
  output logic [AddrWidth-1:0]    mst_ar_addr_o,
  output dw_pkg::len_t            mst_ar_len_o,
  output dw_pkg::size_t           mst_ar_size_o,
  input  logic                    mst_ar_ready_i,
  input  logic                    mst_r_valid_i,
  input  logic [IdWidth-1:0]      mst_r_id_i,
  input  logic [MstDataWidth-1:0] mst_r_data_i,
  input  dw_pkg::resp_t           mst_r_resp_i,
  input  logic                    mst_r_last_i,
  output logic                    mst_r_ready_o
);

  logic [NumLanes-1:0]                   lane_start;
  logic [NumLanes-1:0]                   lane_idle;
  logic [NumLanes-1:0][IdWidth-1:0]      lane_id;
  logic [NumLanes-1:0]                   lane_ar_valid;
  logic [NumLanes-1:0][AddrWidth-1:0]    lane_ar_addr;
  dw_pkg::len_t [NumLanes-1:0]           lane_ar_len;
  dw_pkg::size_t [NumLanes-1:0]          lane_ar_size;
  logic [NumLanes-1:0]                   ar_gnt;
  logic [NumLanes-1:0]                   lane_mst_r_ready;
  logic [NumLanes-1:0]                   lane_r_valid;
  logic [NumLanes-1:0][SlvDataWidth-1:0] lane_r_data;
  dw_pkg::resp_t [NumLanes-1:0]          lane_r_resp;
  logic [NumLanes-1:0]                   lane_r_last;
  logic [NumLanes-1:0]                   r_gnt;

  dw_ar_dispatch #(
    .NumLanes(NumLanes),
    .IdWidth (IdWidth)
  ) i_dispatch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_ar_valid_i(slv_ar_valid_i),
    .slv_ar_id_i   (slv_ar_id_i),
    .lane_idle_i   (lane_idle),
    .lane_id_i     (lane_id),
    .slv_ar_ready_o(slv_ar_ready_o),
    .lane_start_o  (lane_start)
  );

  // Request fields and master R are broadcast, start picks the lane
  for (genvar i = 0; i < NumLanes; i++) begin : gen_lane
    dw_read_lane #(
      .SlvDataWidth(SlvDataWidth),
      .MstDataWidth(MstDataWidth),
      .AddrWidth   (AddrWidth),
      .IdWidth     (IdWidth)
    ) i_lane (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .start_i      (lane_start[i]),
      .slv_ar_id_i  (slv_ar_id_i),
      .slv_ar_addr_i(slv_ar_addr_i),
      .slv_ar_len_i (slv_ar_len_i),
      .slv_ar_size_i(slv_ar_size_i),
      .ar_gnt_i     (ar_gnt[i]),
      .mst_r_valid_i(mst_r_valid_i),
      .mst_r_id_i   (mst_r_id_i),
      .mst_r_data_i (mst_r_data_i),
      .mst_r_resp_i (mst_r_resp_i),
      .mst_r_last_i (mst_r_last_i),
      .r_gnt_i      (r_gnt[i]),
      .idle_o       (lane_idle[i]),
      .id_o         (lane_id[i]),
      .ar_valid_o   (lane_ar_valid[i]),
      .ar_addr_o    (lane_ar_addr[i]),
      .ar_len_o     (lane_ar_len[i]),
      .ar_size_o    (lane_ar_size[i]),
      .mst_r_ready_o(lane_mst_r_ready[i]),
      .r_valid_o    (lane_r_valid[i]),
      .r_data_o     (lane_r_data[i]),
      .r_resp_o     (lane_r_resp[i]),
      .r_last_o     (lane_r_last[i])
    );
  end

  dw_lane_arbiter #(
    .NumLanes    (NumLanes),
    .SlvDataWidth(SlvDataWidth),
    .AddrWidth   (AddrWidth),
    .IdWidth     (IdWidth)
  ) i_arbiter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lane_ar_valid_i   (lane_ar_valid),
    .lane_ar_id_i      (lane_id),
    .lane_ar_addr_i    (lane_ar_addr),
    .lane_ar_len_i     (lane_ar_len),
    .lane_ar_size_i    (lane_ar_size),
    .mst_ar_ready_i    (mst_ar_ready_i),
    .lane_r_valid_i    (lane_r_valid),
    .lane_r_data_i     (lane_r_data),
    .lane_r_resp_i     (lane_r_resp),
    .lane_r_last_i     (lane_r_last),
    .lane_id_i         (lane_id),
    .lane_mst_r_ready_i(lane_mst_r_ready),
    .slv_r_ready_i     (slv_r_ready_i),
    .ar_gnt_o          (ar_gnt),
    .mst_ar_valid_o    (mst_ar_valid_o),
    .mst_ar_id_o       (mst_ar_id_o),
    .mst_ar_addr_o     (mst_ar_addr_o),
    .mst_ar_len_o      (mst_ar_len_o),
    .mst_ar_size_o     (mst_ar_size_o),
    .r_gnt_o           (r_gnt),
    .slv_r_valid_o     (slv_r_valid_o),
    .slv_r_id_o        (slv_r_id_o),
    .slv_r_data_o      (slv_r_data_o),
    .slv_r_resp_o      (slv_r_resp_o),
    .slv_r_last_o      (slv_r_last_o),
    .mst_r_ready_o     (mst_r_ready_o)
  );

endmodule

// ==== dw_asserts.sv ====
module dw_asserts #(
  parameter int unsigned SlvDataWidth = dw_pkg::SlvDataWidth,
  parameter int unsigned MstDataWidth = dw_pkg::MstDataWidth,
  parameter int unsigned AddrWidth    = dw_pkg::AddrWidth,
  parameter int unsigned IdWidth      = dw_pkg::IdWidth
) (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    slv_ar_valid_i,
  input logic                    slv_ar_ready_o,
  input logic [IdWidth-1:0]      slv_ar_id_i,
  input logic [AddrWidth-1:0]    slv_ar_addr_i,
  input dw_pkg::len_t            slv_ar_len_i,
  input dw_pkg::size_t           slv_ar_size_i,
  input logic                    slv_r_valid_o,
  input logic                    slv_r_ready_i,
  input logic [IdWidth-1:0]      slv_r_id_o,
  input logic [SlvDataWidth-1:0] slv_r_data_o,
  input dw_pkg::resp_t           slv_r_resp_o,
  input logic                    slv_r_last_o,
  input logic                    mst_ar_valid_o,
  input logic                    mst_ar_ready_i,
  input logic [IdWidth-1:0]      mst_ar_id_o,
  input logic [AddrWidth-1:0]    mst_ar_addr_o,
  input dw_pkg::len_t            mst_ar_len_o,
  input dw_pkg::size_t           mst_ar_size_o,
  input logic                    mst_r_valid_i,
  input logic                    mst_r_ready_o,
  input logic [IdWidth-1:0]      mst_r_id_i,
  input logic [MstDataWidth-1:0] mst_r_data_i,
  input dw_pkg::resp_t           mst_r_resp_i,
  input logic                    mst_r_last_i
);

  // Valid holds and payload stays put until the handshake
  slv_ar_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_ar_valid_i && !slv_ar_ready_o |=> slv_ar_valid_i &&
    $stable({slv_ar_id_i, slv_ar_addr_i, slv_ar_len_i, slv_ar_size_i}))
    else $error("slave AR dropped or changed while stalled");

  slv_r_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_r_valid_o && !slv_r_ready_i |=> slv_r_valid_o &&
    $stable({slv_r_id_o, slv_r_data_o, slv_r_resp_o, slv_r_last_o}))
    else $error("slave R beat dropped or changed while stalled");

  mst_ar_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o &&
    $stable({mst_ar_id_o, mst_ar_addr_o, mst_ar_len_o, mst_ar_size_o}))
    else $error("master AR dropped or changed while stalled");

  mst_r_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_r_valid_i && !mst_r_ready_o |=> mst_r_valid_i &&
    $stable({mst_r_id_i, mst_r_data_i, mst_r_resp_i, mst_r_last_i}))
    else $error("master R beat dropped or changed while stalled");

  // Quiet outputs while reset is held
  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !slv_ar_ready_o && !mst_ar_valid_o && !slv_r_valid_o && !mst_r_ready_o)
    else $error("DUT output valid or ready during reset");

endmodule

bind axi_read_downsizer dw_asserts #(
  .SlvDataWidth(SlvDataWidth),
  .MstDataWidth(MstDataWidth),
  .AddrWidth   (AddrWidth),
  .IdWidth     (IdWidth)
) i_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .slv_ar_valid_i(slv_ar_valid_i),
  .slv_ar_ready_o(slv_ar_ready_o),
  .slv_ar_id_i   (slv_ar_id_i),
  .slv_ar_addr_i (slv_ar_addr_i),
  .slv_ar_len_i  (slv_ar_len_i),
  .slv_ar_size_i (slv_ar_size_i),
  .slv_r_valid_o (slv_r_valid_o),
  .slv_r_ready_i (slv_r_ready_i),
  .slv_r_id_o    (slv_r_id_o),
  .slv_r_data_o  (slv_r_data_o),
  .slv_r_resp_o  (slv_r_resp_o),
  .slv_r_last_o  (slv_r_last_o),
  .mst_ar_valid_o(mst_ar_valid_o),
  .mst_ar_ready_i(mst_ar_ready_i),
  .mst_ar_id_o   (mst_ar_id_o),
  .mst_ar_addr_o (mst_ar_addr_o),
  .mst_ar_len_o  (mst_ar_len_o),
  .mst_ar_size_o (mst_ar_size_o),
  .mst_r_valid_i (mst_r_valid_i),
  .mst_r_ready_o (mst_r_ready_o),
  .mst_r_id_i    (mst_r_id_i),
  .mst_r_data_i  (mst_r_data_i),
  .mst_r_resp_i  (mst_r_resp_i),
  .mst_r_last_i  (mst_r_last_i)
);

// ==== tb_axi_read_downsizer.sv ====
module tb_axi_read_downsizer;

  localparam int unsigned SlvW     = 64;
  localparam int unsigned MstW     = 32;
  localparam int unsigned AW       = 16;
  localparam int unsigned IW       = 2;
  localparam int unsigned TotalReq = 110;
  localparam int unsigned Watchdog = TotalReq * 40 * 20 + 16 * 20;
  localparam int unsigned HoldMax  = 64;

  typedef struct packed {
    logic [IW-1:0] id;
    logic [AW-1:0] addr;
    logic [7:0]    len;
    logic [2:0]    size;
  } req_t;

  typedef struct packed {
    logic [IW-1:0]   id;
    logic [SlvW-1:0] data;
    logic [1:0]      resp;
    logic            last;
  } beat_t;

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic            slv_ar_valid_i, slv_ar_ready_o;
  logic [IW-1:0]   slv_ar_id_i;
  logic [AW-1:0]   slv_ar_addr_i;
  logic [7:0]      slv_ar_len_i;
  logic [2:0]      slv_ar_size_i;
  logic            slv_r_valid_o, slv_r_ready_i, slv_r_last_o;
  logic [IW-1:0]   slv_r_id_o;
  logic [SlvW-1:0] slv_r_data_o;
  logic [1:0]      slv_r_resp_o;
  logic            mst_ar_valid_o, mst_ar_ready_i;
  logic [IW-1:0]   mst_ar_id_o;
  logic [AW-1:0]   mst_ar_addr_o;
  logic [7:0]      mst_ar_len_o;
  logic [2:0]      mst_ar_size_o;
  logic            mst_r_valid_i, mst_r_ready_o, mst_r_last_i;
  logic [IW-1:0]   mst_r_id_i;
  logic [MstW-1:0] mst_r_data_i;
  logic [1:0]      mst_r_resp_i;

  int    seed;
  int    errors;
  int    total_beats;
  int    beat_idx;
  int    outstanding;
  int    max_out;
  req_t  exp_ar_q[$];
  beat_t exp_r_q[$];
  req_t  serve_q[$];

  axi_read_downsizer uut (.*);

  always #10 clk_i = ~clk_i;

  // Contents of the memory behind the master port
  function automatic logic [7:0] mem_byte(input logic [AW-1:0] a);
    mem_byte = (a[7:0] * 8'd7) ^ a[15:8] ^ 8'h3c;
  endfunction

  function automatic int unsigned rnd(input int unsigned m);
    rnd = $unsigned($random(seed)) % m;
  endfunction

  // Expected master AR and slave beats of one accepted request
  task automatic expect_request(input req_t r);
    req_t          m;
    beat_t         b;
    logic [AW-1:0] ba;
    logic [AW-1:0] a;
    m = r;
    if (r.size > 3'd2) begin
      m.size = 3'd2;
      m.len  = 8'((int'(r.len) + 1) * (1 << (r.size - 3'd2)) - 1);
    end
    exp_ar_q.push_back(m);
    for (int k = 0; k <= int'(r.len); k++) begin
      ba     = r.addr + AW'(k << r.size);
      b.id   = r.id;
      b.data = '0;
      b.resp = dw_pkg::RespOkay;
      b.last = (k == int'(r.len));
      for (int j = 0; j < (1 << r.size); j++) begin
        a = ba + AW'(j);
        b.data[8 * a[2:0] +: 8] = mem_byte(a);
        if (a[12]) b.resp = dw_pkg::RespSlverr;
      end
      exp_r_q.push_back(b);
    end
  endtask

  task automatic check_master_ar();
    int idx;
    idx = -1;
    for (int i = exp_ar_q.size() - 1; i >= 0; i--) begin
      if (exp_ar_q[i].id == mst_ar_id_o) idx = i;
    end
    assert (idx >= 0) else begin
      errors++;
      $display("unexpected master AR with ID %0d at %0t", mst_ar_id_o, $time);
    end
    if (idx >= 0) begin
      assert (exp_ar_q[idx] == {mst_ar_id_o, mst_ar_addr_o, mst_ar_len_o, mst_ar_size_o})
      else begin
        errors++;
        $display("mismatch at %0t: master AR addr %h len %0d size %0d, expected %h %0d %0d",
                 $time, mst_ar_addr_o, mst_ar_len_o, mst_ar_size_o, exp_ar_q[idx].addr,
                 exp_ar_q[idx].len, exp_ar_q[idx].size);
      end
      exp_ar_q.delete(idx);
    end
    serve_q.push_back({mst_ar_id_o, mst_ar_addr_o, mst_ar_len_o, mst_ar_size_o});
    outstanding++;
    if (outstanding > max_out) max_out = outstanding;
  endtask

  task automatic check_slave_r();
    int idx;
    idx = -1;
    for (int i = exp_r_q.size() - 1; i >= 0; i--) begin
      if (exp_r_q[i].id == slv_r_id_o) idx = i;
    end
    assert (idx >= 0) else begin
      errors++;
      $display("slave R beat for ID %0d arrived with no read pending at %0t", slv_r_id_o, $time);
    end
    if (idx >= 0) begin
      assert (exp_r_q[idx] == {slv_r_id_o, slv_r_data_o, slv_r_resp_o, slv_r_last_o}) else begin
        errors++;
        $display("mismatch at %0t: ID %0d data %h resp %0d last %0b, expected %h %0d %0b",
                 $time, slv_r_id_o, slv_r_data_o, slv_r_resp_o, slv_r_last_o,
                 exp_r_q[idx].data, exp_r_q[idx].resp, exp_r_q[idx].last);
      end
      exp_r_q.delete(idx);
    end
  endtask

  // Size mode below 3 means narrow only, 3 wide only, 4 any size
  task automatic run_test(input string name, input int n_req, input int size_mode,
                          input int rdy_pct, input bit ordered);
    int            accepted;
    int            issued;
    int            err0;
    int            beats_exp;
    int            beats_got;
    int            wait_cyc;
    bit            hold_r;
    bit            done;
    bit            slv_ar_hs;
    bit            mst_r_hs;
    logic [AW-1:0] ma;
    logic [2:0]    sz;
    err0      = errors;
    accepted  = 0;
    issued    = 0;
    beats_exp = 0;
    beats_got = 0;
    wait_cyc  = 0;
    max_out   = 0;
    hold_r    = ordered;
    done      = 1'b0;
    slv_ar_hs = 1'b0;
    mst_r_hs  = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      wait_cyc++;
      if (slv_ar_hs) slv_ar_valid_i = 1'b0;
      if (!slv_ar_valid_i && issued < n_req) begin
        sz = (size_mode == 4) ? 3'(rnd(4)) : (size_mode == 3) ? 3'd3 : 3'(rnd(3));
        slv_ar_valid_i = 1'b1;
        slv_ar_size_i  = sz;
        slv_ar_id_i    = ordered ? IW'(issued % 4) : IW'(rnd(4));
        slv_ar_len_i   = 8'(rnd(16));
        slv_ar_addr_i  = AW'(rnd(32768)) & ~AW'((1 << sz) - 1);
        issued++;
      end
      mst_ar_ready_i = (rnd(100) < 70);
      slv_r_ready_i  = (rnd(100) < rdy_pct);
      if (mst_r_hs) mst_r_valid_i = 1'b0;
      // Master holds its answers until four reads are outstanding or the wait runs out
      if (hold_r && (max_out >= 4 || wait_cyc >= HoldMax)) hold_r = 1'b0;
      if (!mst_r_valid_i && serve_q.size() > 0 && !hold_r && rnd(100) < 80) begin
        ma = serve_q[0].addr + AW'(beat_idx << serve_q[0].size);
        for (int b = 0; b < 4; b++) begin
          mst_r_data_i[8 * b +: 8] = mem_byte({ma[15:2], 2'(b)});
        end
        mst_r_valid_i = 1'b1;
        mst_r_id_i    = serve_q[0].id;
        mst_r_resp_i  = ma[12] ? dw_pkg::RespSlverr : dw_pkg::RespOkay;
        mst_r_last_i  = (beat_idx == int'(serve_q[0].len));
      end
      #5;
      slv_ar_hs = slv_ar_valid_i && slv_ar_ready_o;
      mst_r_hs  = mst_r_valid_i && mst_r_ready_o;
      if (slv_ar_hs) begin
        expect_request({slv_ar_id_i, slv_ar_addr_i, slv_ar_len_i, slv_ar_size_i});
        beats_exp += int'(slv_ar_len_i) + 1;
        accepted++;
      end
      if (mst_ar_valid_o && mst_ar_ready_i) check_master_ar();
      if (mst_r_hs) begin
        beat_idx++;
        if (mst_r_last_i) begin
          void'(serve_q.pop_front());
          beat_idx = 0;
          outstanding--;
        end
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        check_slave_r();
        beats_got++;
      end
      done = (accepted == n_req) && exp_r_q.size() == 0 && serve_q.size() == 0 &&
             exp_ar_q.size() == 0;
      @(posedge clk_i);
    end
    @(negedge clk_i);
    slv_ar_valid_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    assert (beats_got == beats_exp) else begin
      errors++;
      $display("mismatch at %0t: %0d slave beats, expected %0d", $time, beats_got, beats_exp);
    end
    if (ordered) begin
      assert (max_out == 4) else begin
        errors++;
        $display("master port never saw four reads outstanding, peak was %0d", max_out);
      end
    end
    total_beats += beats_got;
    $display("test %s: %0d requests, %0d slave beats, %0d errors", name, n_req, beats_got,
             errors - err0);
  endtask

  initial begin
    seed           = 32'h1634_e6b9;
    errors         = 0;
    total_beats    = 0;
    beat_idx       = 0;
    outstanding    = 0;
    max_out        = 0;
    rst_ni         = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_ar_size_i  = '0;
    slv_r_ready_i  = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    run_test("narrow", 20, 0, 75, 1'b0);
    run_test("wide", 20, 3, 75, 1'b0);
    run_test("response_last", 20, 4, 75, 1'b0);
    run_test("ordering", 20, 4, 75, 1'b1);
    run_test("backpressure", 30, 4, 50, 1'b0);
    $display("summary: 5 tests, %0d slave beats, %0d errors", total_beats, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Hang guard sized from the request count
  initial begin
    #(Watchdog);
    $display("timeout: the DUT stopped completing reads before all tests finished");
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== sources.f ====
dw_pkg.sv
dw_ar_dispatch.sv
dw_read_lane.sv
dw_lane_arbiter.sv
axi_read_downsizer.sv
dw_asserts.sv
tb_axi_read_downsizer.sv

// ==== Makefile ====
# Verilator build and run of the AXI read downsizer testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_read_downsizer
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --assert --timing -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
